/* list.f */
+incdir+src
src/core_pkg.sv
src/reg_file.sv
src/issue_stage.sv
src/int_pipe.sv
src/ls_pipe.sv
src/exec_core.sv
sim/exec_checker.sv
sim/tb_exec_core.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the exec_core testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f list.f --top-module tb_exec_core -Mdir obj_dir -o tb_exec_core
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_exec_core > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "STATUS: FAIL" "$LOG"; then
    exit 1
fi
if ! grep -q "STATUS: PASS" "$LOG"; then
    echo "No result line found in $LOG"
    exit 1
fi
exit 0

/* sim/tb_exec_core.sv */
`timescale 1ns/1ns
`include "core_config.svh"

module tb_exec_core;

    logic                 clk;
    logic                 rst;
    logic                 dec_valid;
    core_pkg::dec_instr_t dec_instr;
    logic                 dec_ready;
    core_pkg::wb_t        ip_wb;
    core_pkg::wb_t        lsp_wb;
    int                   chk_errors;
    int                   pending;
    int                   stall_count;

    // Instruction table with the test each entry belongs to
    core_pkg::dec_instr_t tbl      [`TB_TABLE_LEN];
    int                   tbl_test [`TB_TABLE_LEN];
    int                   tbl_n;
    logic [63:0]          rng_state;
    int                   tb_errors;
    int                   tests_run;
    int                   tests_failed;
    int                   errors_before;
    int                   stalls_before;
    logic                 timed_out;
    string                test_names [7];

    exec_core DUT (
        .clk       (clk),
        .rst       (rst),
        .dec_valid (dec_valid),
        .dec_instr (dec_instr),
        .dec_ready (dec_ready),
        .ip_wb     (ip_wb),
        .lsp_wb    (lsp_wb)
    );

    exec_checker u_checker (
        .clk         (clk),
        .rst         (rst),
        .dec_valid   (dec_valid),
        .dec_ready   (dec_ready),
        .dec_instr   (dec_instr),
        .ip_wb       (ip_wb),
        .lsp_wb      (lsp_wb),
        .error_count (chk_errors),
        .pending     (pending),
        .stall_count (stall_count)
    );

    always #4 clk = ~clk;

    function automatic logic [63:0] xorshift(input logic [63:0] s);
        logic [63:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 7);
        x = x ^ (x << 17);
        return x;
    endfunction

    function automatic logic [63:0] next_rand();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    function automatic core_pkg::dec_instr_t make_instr(
        input core_pkg::op_type_e   t,
        input core_pkg::alu_op_e    op,
        input core_pkg::opr1_sel_e  s1,
        input core_pkg::opr2_sel_e  s2,
        input int                   rs1,
        input int                   rs2,
        input int                   rd,
        input logic [63:0]          imm,
        input logic                 sign,
        input core_pkg::mem_width_e w
    );
        core_pkg::dec_instr_t d;
        d           = '0;
        d.op_type   = t;
        d.op        = op;
        d.opr1_sel  = s1;
        d.opr2_sel  = s2;
        d.rs1       = 5'(rs1);
        d.rs2       = 5'(rs2);
        d.rd        = 5'(rd);
        d.imm       = imm;
        d.wb_en     = (t != core_pkg::OT_STORE);
        d.mem_sign  = sign;
        d.mem_width = w;
        return d;
    endfunction

    task automatic add_entry(input int test, input core_pkg::dec_instr_t d);
        d.pc            = 64'h1000 + 64'(tbl_n * 4);
        tbl[tbl_n]      = d;
        tbl_test[tbl_n] = test;
        tbl_n++;
    endtask

    task automatic add_alu(input int test, input int op, input core_pkg::opr1_sel_e s1,
                           input core_pkg::opr2_sel_e s2, input int rs1, input int rs2,
                           input int rd, input logic [63:0] imm);
        add_entry(test, make_instr(core_pkg::OT_INT, core_pkg::alu_op_e'(op), s1, s2,
                                   rs1, rs2, rd, imm, 1'b0, core_pkg::MW_DOUBLE));
    endtask

    // Base register x0, so the immediate is the address
    task automatic add_mem(input int test, input core_pkg::op_type_e t, input int data_reg,
                           input int addr, input logic sign, input core_pkg::mem_width_e w);
        add_entry(test, make_instr(t, core_pkg::ALU_ADD, core_pkg::OPR1_RS1, core_pkg::OPR2_IMM,
                                   0, data_reg, data_reg, 64'(addr), sign, w));
    endtask

    task automatic build_table();
        core_pkg::mem_width_e w;
        int addr;
        int nb;
        // Seed x1..x8 with random values
        for (int r = 1; r <= 8; r++) begin
            add_alu(1, 0, core_pkg::OPR1_ZERO, core_pkg::OPR2_IMM, 0, 0, r, next_rand());
        end
        for (int op = 0; op < 8; op++) begin
            add_alu(1, op, core_pkg::OPR1_RS1, core_pkg::OPR2_RS2, op + 1, (op + 3) % 8 + 1,
                    10 + op, 64'h0);
            add_alu(1, op, core_pkg::OPR1_RS1, core_pkg::OPR2_IMM, op + 1, 0, 18 + op,
                    next_rand());
        end
        add_alu(1, 0, core_pkg::OPR1_PC, core_pkg::OPR2_FOUR, 0, 0, 26, 64'h0);
        add_alu(1, 1, core_pkg::OPR1_PC, core_pkg::OPR2_IMM, 0, 0, 27, next_rand());
        // Chains at distances one and two
        for (int i = 0; i < 12; i++) begin
            add_alu(2, i % 8, core_pkg::OPR1_RS1, core_pkg::OPR2_RS2, (i + 5) % 6 + 1,
                    (i + 4) % 6 + 1, i % 6 + 1, 64'h0);
        end
        // Load use and write after write on the load destination
        for (int i = 0; i < 3; i++) begin
            addr = i * 64;
            add_mem(3, core_pkg::OT_STORE, i + 1, addr, 1'b0, core_pkg::MW_DOUBLE);
            add_mem(3, core_pkg::OT_LOAD, 9, addr, 1'b0, core_pkg::MW_DOUBLE);
            add_alu(3, 0, core_pkg::OPR1_RS1, core_pkg::OPR2_RS2, 9, 2, 10, 64'h0);
            add_mem(3, core_pkg::OT_LOAD, 11, addr, 1'b0, core_pkg::MW_DOUBLE);
            add_alu(3, 0, core_pkg::OPR1_ZERO, core_pkg::OPR2_IMM, 0, 0, 11, next_rand());
            add_alu(3, 0, core_pkg::OPR1_RS1, core_pkg::OPR2_RS2, 11, 0, 12, 64'h0);
        end
        // Naturally aligned stores and loads of every width
        for (int i = 0; i < 24; i++) begin
            w    = core_pkg::mem_width_e'(next_rand() % 4);
            nb   = 1 << int'(w);
            addr = int'(next_rand() % 512) & ~(nb - 1);
            add_mem(4, core_pkg::OT_STORE, i % 8 + 1, addr, 1'b0, w);
            w    = core_pkg::mem_width_e'(next_rand() % 4);
            nb   = 1 << int'(w);
            addr = (addr & ~7) + (int'(next_rand() % 8) & ~(nb - 1));
            add_mem(4, core_pkg::OT_LOAD, 13 + i % 4, addr, next_rand() % 2 == 0, w);
        end
        // x0 stays zero
        add_alu(5, 0, core_pkg::OPR1_ZERO, core_pkg::OPR2_IMM, 0, 0, 0, next_rand());
        add_alu(5, 0, core_pkg::OPR1_RS1, core_pkg::OPR2_RS2, 0, 0, 13, 64'h0);
        add_mem(5, core_pkg::OT_LOAD, 0, 0, 1'b1, core_pkg::MW_DOUBLE);
        add_alu(5, 3, core_pkg::OPR1_RS1, core_pkg::OPR2_IMM, 0, 0, 14, 64'h5a);
    endtask

    task automatic wait_drain(output logic expired);
        int waited;
        waited  = 0;
        expired = 1'b0;
        while (pending != 0 && !expired) begin
            @(negedge clk);
            waited++;
            if (waited > 100) begin
                $display("Timeout while waiting for outstanding writebacks");
                expired = 1'b1;
            end
        end
    endtask

    // Holds the entry until the DUT takes it
    task automatic drive_entry(input int i, output logic expired);
        int   waited;
        logic taken;
        waited    = 0;
        taken     = 1'b0;
        expired   = 1'b0;
        dec_valid = 1'b1;
        dec_instr = tbl[i];
        while (!taken && !expired) begin
            @(negedge clk);
            taken = dec_ready;
            @(posedge clk);
            waited++;
            if (!taken && waited >= 50) begin
                $display("Timeout while waiting for dec_ready");
                expired = 1'b1;
            end
        end
        #1;
        dec_valid = 1'b0;
    endtask

    task automatic report_test(input int test);
        int errs;
        errs = chk_errors + tb_errors - errors_before;
        tests_run++;
        if (errs != 0) begin
            tests_failed++;
        end
        $display("test %0d %s: %0d errors", test, test_names[test], errs);
        errors_before = chk_errors + tb_errors;
    endtask

    initial begin
        test_names[0] = "unused";
        test_names[1] = "alu ops and operand selects";
        test_names[2] = "forwarding chains";
        test_names[3] = "load use stall";
        test_names[4] = "store and load widths";
        test_names[5] = "register zero";
        test_names[6] = "reset behavior";
        clk           = 1'b0;
        rst           = 1'b1;
        dec_valid     = 1'b0;
        dec_instr     = '0;
        rng_state     = 64'd26;
        tbl_n         = 0;
        tb_errors     = 0;
        tests_run     = 0;
        tests_failed  = 0;
        errors_before = 0;
        timed_out     = 1'b0;
        build_table();
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (3) @(posedge clk);
        report_test(6);
        #1;
        stalls_before = stall_count;
        for (int i = 0; i < tbl_n && !timed_out; i++) begin
            drive_entry(i, timed_out);
            if (!timed_out && (i == tbl_n - 1 || tbl_test[i + 1] != tbl_test[i])) begin
                wait_drain(timed_out);
                if (!timed_out) begin
                    if (tbl_test[i] == 3 && stall_count == stalls_before) begin
                        $display("Load followed by a dependent instruction did not stall");
                        tb_errors++;
                    end
                    report_test(tbl_test[i]);
                    stalls_before = stall_count;
                end
            end
        end
        $display("tests: %0d run, %0d failed, %0d errors",
                 tests_run, tests_failed, chk_errors + tb_errors);
        if (!timed_out && chk_errors + tb_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* sim/exec_checker.sv */
`timescale 1ns/1ns
`include "core_config.svh"

module exec_checker (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 dec_valid,
    input  logic                 dec_ready,
    input  core_pkg::dec_instr_t dec_instr,
    input  core_pkg::wb_t        ip_wb,
    input  core_pkg::wb_t        lsp_wb,
    output int                   error_count,
    output int                   pending,
    output int                   stall_count
);

    localparam int MEM_BYTES = `DMEM_WORDS * 8;

    // Reference state, x0 is never written
    logic [`XLEN-1:0] model_regs [`REG_COUNT];
    logic [7:0]       model_mem  [MEM_BYTES];
    core_pkg::wb_t    exp_ip [$];
    core_pkg::wb_t    exp_ls [$];
    int               cycles_after_rst;
    int               rst_edges;

    initial begin
        error_count      = 0;
        pending          = 0;
        stall_count      = 0;
        cycles_after_rst = 0;
        rst_edges        = 0;
        for (int i = 0; i < `REG_COUNT; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < MEM_BYTES; i++) begin
            model_mem[i] = '0;
        end
    end

    function automatic int width_bytes(input core_pkg::mem_width_e w);
        case (w)
            core_pkg::MW_BYTE: return 1;
            core_pkg::MW_HALF: return 2;
            core_pkg::MW_WORD: return 4;
            default:           return 8;
        endcase
    endfunction

    function automatic int byte_index(input logic [`XLEN-1:0] addr, input int b);
        return int'((addr + `XLEN'(b)) % `XLEN'(MEM_BYTES));
    endfunction

    task automatic model_accept(input core_pkg::dec_instr_t d);
        logic [`XLEN-1:0] opr1;
        logic [`XLEN-1:0] opr2;
        logic [`XLEN-1:0] addr;
        logic [`XLEN-1:0] value;
        core_pkg::wb_t    e;
        int               nb;
        e       = '0;
        e.valid = 1'b1;
        e.pc    = d.pc;
        e.dst   = d.rd;
        case (d.opr1_sel)
            core_pkg::OPR1_RS1: opr1 = model_regs[d.rs1];
            core_pkg::OPR1_PC:  opr1 = d.pc;
            default:            opr1 = '0;
        endcase
        case (d.opr2_sel)
            core_pkg::OPR2_RS2: opr2 = model_regs[d.rs2];
            core_pkg::OPR2_IMM: opr2 = d.imm;
            default:            opr2 = `XLEN'd4;
        endcase
        if (d.op_type == core_pkg::OT_INT) begin
            case (d.op)
                core_pkg::ALU_ADD: value = opr1 + opr2;
                core_pkg::ALU_SUB: value = opr1 - opr2;
                core_pkg::ALU_AND: value = opr1 & opr2;
                core_pkg::ALU_OR:  value = opr1 | opr2;
                core_pkg::ALU_XOR: value = opr1 ^ opr2;
                core_pkg::ALU_SLL: value = opr1 << opr2[5:0];
                core_pkg::ALU_SRL: value = opr1 >> opr2[5:0];
                default:           value = ($signed(opr1) < $signed(opr2)) ? `XLEN'd1 : '0;
            endcase
            e.wb_en  = d.wb_en;
            e.result = value;
            exp_ip.push_back(e);
        end else begin
            addr = opr1 + {{(`XLEN-12){d.imm[11]}}, d.imm[11:0]};
            nb   = width_bytes(d.mem_width);
            if (d.op_type == core_pkg::OT_STORE) begin
                for (int b = 0; b < nb; b++) begin
                    model_mem[byte_index(addr, b)] = model_regs[d.rs2][b*8 +: 8];
                end
                e.wb_en = 1'b0;
            end else begin
                value = '0;
                for (int b = 0; b < nb; b++) begin
                    value[b*8 +: 8] = model_mem[byte_index(addr, b)];
                end
                if (nb < 8 && d.mem_sign && value[nb*8-1]) begin
                    value = value | ~((`XLEN'd1 << (nb * 8)) - `XLEN'd1);
                end
                e.wb_en  = d.wb_en;
                e.result = value;
            end
            exp_ls.push_back(e);
        end
        if (e.wb_en && d.rd != '0) begin
            model_regs[d.rd] = e.result;
        end
    endtask

    task automatic compare(input string name, input core_pkg::wb_t got, input core_pkg::wb_t exp);
        if (got.pc !== exp.pc) begin
            $display("ERROR: %s.pc got %h expected %h", name, got.pc, exp.pc);
            error_count++;
        end else if (got.wb_en !== exp.wb_en) begin
            $display("ERROR: %s.wb_en pc=%h got %h expected %h",
                     name, got.pc, got.wb_en, exp.wb_en);
            error_count++;
        end else if (exp.wb_en && got.dst !== exp.dst) begin
            $display("ERROR: %s.dst pc=%h got %h expected %h", name, got.pc, got.dst, exp.dst);
            error_count++;
        end else if (exp.wb_en && got.result !== exp.result) begin
            $display("ERROR: %s.result pc=%h got %h expected %h",
                     name, got.pc, got.result, exp.result);
            error_count++;
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            cycles_after_rst = 0;
            rst_edges++;
            // The first edge only loads the reset values
            if (rst_edges > 1 && (ip_wb.valid !== 1'b0 || lsp_wb.valid !== 1'b0)) begin
                $display("Writeback valid was not low while reset was held");
                error_count++;
            end
        end else begin
            cycles_after_rst++;
            if (cycles_after_rst == 2 && dec_ready !== 1'b1) begin
                $display("ERROR: dec_ready got %h expected 1 after reset", dec_ready);
                error_count++;
            end
            if (ip_wb.valid === 1'b1) begin
                if (exp_ip.size() == 0) begin
                    $display("Integer writeback arrived with no instruction outstanding");
                    error_count++;
                end else begin
                    compare("ip_wb", ip_wb, exp_ip.pop_front());
                end
            end
            if (lsp_wb.valid === 1'b1) begin
                if (exp_ls.size() == 0) begin
                    $display("Load/store writeback arrived with no instruction outstanding");
                    error_count++;
                end else begin
                    compare("lsp_wb", lsp_wb, exp_ls.pop_front());
                end
            end
            if (dec_valid && !dec_ready) begin
                stall_count++;
            end
            if (dec_valid && dec_ready) begin
                model_accept(dec_instr);
            end
        end
        pending = exp_ip.size() + exp_ls.size();
    end

endmodule

/* src/exec_core.sv */
`timescale 1ns/1ns
`include "core_config.svh"

module exec_core (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  dec_valid,
    input  core_pkg::dec_instr_t  dec_instr,
    output logic                  dec_ready,
    output core_pkg::wb_t         ip_wb,
    output core_pkg::wb_t         lsp_wb
);

    core_pkg::reg_idx_t   rs1;
    core_pkg::reg_idx_t   rs2;
    logic [`XLEN-1:0]     rdata0;
    logic [`XLEN-1:0]     rdata1;
    core_pkg::ip_instr_t  ip_issue;
    logic                 ip_valid;
    core_pkg::lsp_instr_t lsp_issue;
    logic                 lsp_valid;
    core_pkg::wb_t        ip_fwd;
    core_pkg::wb_t        lsp_busy_ag;
    core_pkg::wb_t        lsp_busy_mem;

    reg_file u_reg_file (
        .clk    (clk),
        .rst    (rst),
        .rs1    (rs1),
        .rs2    (rs2),
        .rdata0 (rdata0),
        .rdata1 (rdata1),
        .ip_wb  (ip_wb),
        .lsp_wb (lsp_wb)
    );

    issue_stage u_issue_stage (
        .clk          (clk),
        .rst          (rst),
        .dec_valid    (dec_valid),
        .dec_instr    (dec_instr),
        .dec_ready    (dec_ready),
        .rs1          (rs1),
        .rs2          (rs2),
        .rdata0       (rdata0),
        .rdata1       (rdata1),
        .ip_fwd       (ip_fwd),
        .ip_wb        (ip_wb),
        .lsp_wb       (lsp_wb),
        .lsp_busy_ag  (lsp_busy_ag),
        .lsp_busy_mem (lsp_busy_mem),
        .ip_issue     (ip_issue),
        .ip_valid     (ip_valid),
        .lsp_issue    (lsp_issue),
        .lsp_valid    (lsp_valid)
    );

    int_pipe u_int_pipe (
        .clk      (clk),
        .rst      (rst),
        .ip_issue (ip_issue),
        .ip_valid (ip_valid),
        .ip_fwd   (ip_fwd),
        .ip_wb    (ip_wb)
    );

    ls_pipe u_ls_pipe (
        .clk          (clk),
        .rst          (rst),
        .lsp_issue    (lsp_issue),
        .lsp_valid    (lsp_valid),
        .lsp_busy_ag  (lsp_busy_ag),
        .lsp_busy_mem (lsp_busy_mem),
        .lsp_wb       (lsp_wb)
    );

endmodule

/* src/ls_pipe.sv */
`timescale 1ns/1ns
`include "core_config.svh"

module ls_pipe (
    input  logic                   clk,
    input  logic                   rst,
    input  core_pkg::lsp_instr_t   lsp_issue,
    input  logic                   lsp_valid,
    output core_pkg::wb_t          lsp_busy_ag,
    output core_pkg::wb_t          lsp_busy_mem,
    output core_pkg::wb_t          lsp_wb
);

    localparam int AW = $clog2(`DMEM_WORDS);

    logic [`XLEN-1:0] dmem [`DMEM_WORDS];

    // Address generation
    logic [`XLEN-1:0] ag_addr;
    logic [2:0]       ag_lane;
    logic [7:0]       ag_be;

    // Memory access stage
    logic                 ms_valid;
    logic                 ms_is_store;
    logic [AW-1:0]        ms_idx;
    logic [2:0]           ms_lane;
    logic [7:0]           ms_be;
    logic [`XLEN-1:0]     ms_wdata;
    logic                 ms_sign;
    core_pkg::mem_width_e ms_width;
    core_pkg::reg_idx_t   ms_dst;
    logic                 ms_wb_en;
    logic [`XLEN-1:0]     ms_pc;

    // Writeback stage
    logic                 wb_valid;
    logic                 wb_en;
    core_pkg::reg_idx_t   wb_dst;
    logic [`XLEN-1:0]     wb_pc;
    logic [`XLEN-1:0]     wb_word;
    logic [2:0]           wb_lane;
    logic                 wb_sign;
    core_pkg::mem_width_e wb_width;
    logic [`XLEN-1:0]     wb_shifted;
    logic [`XLEN-1:0]     wb_result;

    assign ag_addr = lsp_issue.base + {{(`XLEN-12){lsp_issue.offset[11]}}, lsp_issue.offset};
    assign ag_lane = ag_addr[2:0];

    always_comb begin
        case (lsp_issue.mem_width)
            core_pkg::MW_BYTE: ag_be = 8'h01 << ag_lane;
            core_pkg::MW_HALF: ag_be = 8'h03 << ag_lane;
            core_pkg::MW_WORD: ag_be = 8'h0f << ag_lane;
            default:           ag_be = 8'hff;
        endcase
    end

    // Only loads produce a register result worth stalling on
    assign lsp_busy_ag  = '{valid: lsp_valid && !lsp_issue.is_store, wb_en: lsp_issue.wb_en,
                            dst: lsp_issue.dst, result: '0, pc: lsp_issue.pc};
    assign lsp_busy_mem = '{valid: ms_valid && !ms_is_store, wb_en: ms_wb_en,
                            dst: ms_dst, result: '0, pc: ms_pc};

    always_ff @(posedge clk) begin
        ms_valid <= lsp_valid;
        wb_valid <= ms_valid;
        if (rst) begin
            ms_valid <= 1'b0;
            wb_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        ms_is_store <= lsp_issue.is_store;
        ms_idx      <= ag_addr[3 +: AW];
        ms_lane     <= ag_lane;
        ms_be       <= ag_be;
        ms_wdata    <= lsp_issue.source << {ag_lane, 3'b000};
        ms_sign     <= lsp_issue.mem_sign;
        ms_width    <= lsp_issue.mem_width;
        ms_dst      <= lsp_issue.dst;
        ms_wb_en    <= lsp_issue.wb_en;
        ms_pc       <= lsp_issue.pc;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (ms_valid && ms_is_store) begin
            for (int b = 0; b < 8; b++) begin
                if (ms_be[b]) begin
                    dmem[ms_idx][b*8 +: 8] <= ms_wdata[b*8 +: 8];
                end
            end
        end
    end

    // Word read takes one cycle, lane select follows the register
    always_ff @(posedge clk) begin
        wb_word  <= dmem[ms_idx];
        wb_en    <= ms_wb_en && !ms_is_store;
        wb_dst   <= ms_dst;
        wb_pc    <= ms_pc;
        wb_lane  <= ms_lane;
        wb_sign  <= ms_sign;
        wb_width <= ms_width;
    end

    assign wb_shifted = wb_word >> {wb_lane, 3'b000};

    always_comb begin
        case (wb_width)
            core_pkg::MW_BYTE:
                wb_result = {{(`XLEN-8){wb_sign & wb_shifted[7]}}, wb_shifted[7:0]};
            core_pkg::MW_HALF:
                wb_result = {{(`XLEN-16){wb_sign & wb_shifted[15]}}, wb_shifted[15:0]};
            core_pkg::MW_WORD:
                wb_result = {{(`XLEN-32){wb_sign & wb_shifted[31]}}, wb_shifted[31:0]};
            default:
                wb_result = wb_shifted;
        endcase
    end

    assign lsp_wb = '{valid: wb_valid, wb_en: wb_en, dst: wb_dst,
                      result: wb_result, pc: wb_pc};

endmodule

/* src/int_pipe.sv */
`timescale 1ns/1ns
`include "core_config.svh"

module int_pipe (
    input  logic                  clk,
    input  logic                  rst,
    input  core_pkg::ip_instr_t   ip_issue,
    input  logic                  ip_valid,
    output core_pkg::wb_t         ip_fwd,
    output core_pkg::wb_t         ip_wb
);

    logic [`XLEN-1:0] opa;
    logic [`XLEN-1:0] opb;
    logic [5:0]       shamt;
    logic [`XLEN-1:0] alu_result;

    assign opa   = ip_issue.operand1;
    assign opb   = ip_issue.operand2;
    assign shamt = opb[5:0];

    always_comb begin
        case (ip_issue.op)
            core_pkg::ALU_ADD: alu_result = opa + opb;
            core_pkg::ALU_SUB: alu_result = opa - opb;
            core_pkg::ALU_AND: alu_result = opa & opb;
            core_pkg::ALU_OR:  alu_result = opa | opb;
            core_pkg::ALU_XOR: alu_result = opa ^ opb;
            core_pkg::ALU_SLL: alu_result = opa << shamt;
            core_pkg::ALU_SRL: alu_result = opa >> shamt;
            core_pkg::ALU_SLT: begin
                // Signed compare, result is 0 or 1
                alu_result = {{(`XLEN-1){1'b0}}, ($signed(opa) < $signed(opb))};
            end
            default:           alu_result = '0;
        endcase
    end

    // Execute stage result, visible to issue in the same cycle
    always_comb begin
        ip_fwd.valid  = ip_valid;
        ip_fwd.wb_en  = ip_issue.wb_en;
        ip_fwd.dst    = ip_issue.dst;
        ip_fwd.result = alu_result;
        ip_fwd.pc     = ip_issue.pc;
    end

    always_ff @(posedge clk) begin
        ip_wb <= ip_fwd;
        if (rst) begin
            ip_wb.valid <= 1'b0;
        end
    end

endmodule

/* src/issue_stage.sv */
`timescale 1ns/1ns
`include "core_config.svh"

module issue_stage (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   dec_valid,
    input  core_pkg::dec_instr_t   dec_instr,
    output logic                   dec_ready,
    output core_pkg::reg_idx_t     rs1,
    output core_pkg::reg_idx_t     rs2,
    input  logic [`XLEN-1:0]       rdata0,
    input  logic [`XLEN-1:0]       rdata1,
    input  core_pkg::wb_t          ip_fwd,
    input  core_pkg::wb_t          ip_wb,
    input  core_pkg::wb_t          lsp_wb,
    input  core_pkg::wb_t          lsp_busy_ag,
    input  core_pkg::wb_t          lsp_busy_mem,
    output core_pkg::ip_instr_t    ip_issue,
    output logic                   ip_valid,
    output core_pkg::lsp_instr_t   lsp_issue,
    output logic                   lsp_valid
);

    logic             ready_q;
    logic             rs1_needed;
    logic             rs2_needed;
    logic             load_hazard;
    logic             accept;
    logic             issue_ip;
    logic             issue_lsp;
    logic [`XLEN-1:0] rs1_val;
    logic [`XLEN-1:0] rs2_val;
    logic [`XLEN-1:0] opr1_val;
    logic [`XLEN-1:0] opr2_val;

    // True when a record will write the given register
    function automatic logic reg_hit(input core_pkg::wb_t w, input core_pkg::reg_idx_t idx);
        return w.valid && w.wb_en && (w.dst == idx) && (idx != '0);
    endfunction

    // Youngest value wins, x0 never matches a hit
    function automatic logic [`XLEN-1:0] src_value(
        input core_pkg::reg_idx_t idx,
        input logic [`XLEN-1:0]   rf_val
    );
        if (reg_hit(lsp_wb, idx)) begin
            return lsp_wb.result;
        end else if (reg_hit(ip_fwd, idx)) begin
            return ip_fwd.result;
        end else if (reg_hit(ip_wb, idx)) begin
            return ip_wb.result;
        end
        return (idx == '0) ? '0 : rf_val;
    endfunction

    function automatic logic load_pending(input core_pkg::reg_idx_t idx);
        return reg_hit(lsp_busy_ag, idx) || reg_hit(lsp_busy_mem, idx);
    endfunction

    assign rs1 = dec_instr.rs1;
    assign rs2 = dec_instr.rs2;

    assign rs1_val = src_value(dec_instr.rs1, rdata0);
    assign rs2_val = src_value(dec_instr.rs2, rdata1);

    // Stores always read rs2 as their data source
    assign rs1_needed = (dec_instr.opr1_sel == core_pkg::OPR1_RS1);
    assign rs2_needed = (dec_instr.opr2_sel == core_pkg::OPR2_RS2) ||
                        (dec_instr.op_type == core_pkg::OT_STORE);

    // The destination check stops a younger result being overwritten by a load
    assign load_hazard = (rs1_needed && load_pending(dec_instr.rs1)) ||
                         (rs2_needed && load_pending(dec_instr.rs2)) ||
                         (dec_instr.wb_en && load_pending(dec_instr.rd));

    assign dec_ready = ready_q && !load_hazard;
    assign accept    = dec_valid && dec_ready;
    assign issue_ip  = accept && (dec_instr.op_type == core_pkg::OT_INT);
    assign issue_lsp = accept && (dec_instr.op_type != core_pkg::OT_INT);

    always_comb begin
        case (dec_instr.opr1_sel)
            core_pkg::OPR1_RS1: opr1_val = rs1_val;
            core_pkg::OPR1_PC:  opr1_val = dec_instr.pc;
            default:            opr1_val = '0;
        endcase
        case (dec_instr.opr2_sel)
            core_pkg::OPR2_RS2: opr2_val = rs2_val;
            core_pkg::OPR2_IMM: opr2_val = dec_instr.imm;
            default:            opr2_val = `XLEN'd4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ready_q   <= 1'b0;
            ip_valid  <= 1'b0;
            lsp_valid <= 1'b0;
        end else begin
            ready_q   <= 1'b1;
            ip_valid  <= issue_ip;
            lsp_valid <= issue_lsp;
        end
    end

    // Dispatch payloads only move on issue
    always_ff @(posedge clk) begin
        if (issue_ip) begin
            ip_issue.pc       <= dec_instr.pc;
            ip_issue.op       <= dec_instr.op;
            ip_issue.operand1 <= opr1_val;
            ip_issue.operand2 <= opr2_val;
            ip_issue.dst      <= dec_instr.rd;
            ip_issue.wb_en    <= dec_instr.wb_en;
        end
        if (issue_lsp) begin
            lsp_issue.pc        <= dec_instr.pc;
            lsp_issue.is_store  <= (dec_instr.op_type == core_pkg::OT_STORE);
            lsp_issue.base      <= opr1_val;
            lsp_issue.offset    <= dec_instr.imm[11:0];
            lsp_issue.source    <= rs2_val;
            lsp_issue.mem_sign  <= dec_instr.mem_sign;
            lsp_issue.mem_width <= dec_instr.mem_width;
            lsp_issue.dst       <= dec_instr.rd;
            lsp_issue.wb_en     <= dec_instr.wb_en;
        end
    end

endmodule

/* src/reg_file.sv */
`timescale 1ns/1ns
`include "core_config.svh"

module reg_file (
    input  logic                 clk,
    input  logic                 rst,
    input  core_pkg::reg_idx_t   rs1,
    input  core_pkg::reg_idx_t   rs2,
    output logic [`XLEN-1:0]     rdata0,
    output logic [`XLEN-1:0]     rdata1,
    input  core_pkg::wb_t        ip_wb,
    input  core_pkg::wb_t        lsp_wb
);

    // x0 has no storage
    logic [`XLEN-1:0] regs [1:`REG_COUNT-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (ip_wb.valid && ip_wb.wb_en && (ip_wb.dst != '0)) begin
                regs[ip_wb.dst] <= ip_wb.result;
            end
            // Hazard rules keep both ports off the same register
            if (lsp_wb.valid && lsp_wb.wb_en && (lsp_wb.dst != '0)) begin
                regs[lsp_wb.dst] <= lsp_wb.result;
            end
        end
    end

    assign rdata0 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata1 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* src/core_pkg.sv */
`include "core_config.svh"

package core_pkg;

    typedef logic [$clog2(`REG_COUNT)-1:0] reg_idx_t;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLL = 4'd5,
        ALU_SRL = 4'd6,
        ALU_SLT = 4'd7
    } alu_op_e;

    typedef enum logic [1:0] {
        OPR1_RS1  = 2'd0,
        OPR1_PC   = 2'd1,
        OPR1_ZERO = 2'd2
    } opr1_sel_e;

    typedef enum logic [1:0] {
        OPR2_RS2  = 2'd0,
        OPR2_IMM  = 2'd1,
        OPR2_FOUR = 2'd2
    } opr2_sel_e;

    typedef enum logic [1:0] {
        OT_INT   = 2'd0,
        OT_LOAD  = 2'd1,
        OT_STORE = 2'd2
    } op_type_e;

    typedef enum logic [1:0] {
        MW_BYTE   = 2'd0,
        MW_HALF   = 2'd1,
        MW_WORD   = 2'd2,
        MW_DOUBLE = 2'd3
    } mem_width_e;

    // Decoded instruction as handed over by the decoder
    typedef struct packed {
        logic [`XLEN-1:0] pc;
        alu_op_e          op;
        op_type_e         op_type;
        opr1_sel_e        opr1_sel;
        opr2_sel_e        opr2_sel;
        logic [`XLEN-1:0] imm;
        reg_idx_t         rs1;
        reg_idx_t         rs2;
        reg_idx_t         rd;
        logic             wb_en;
        logic             mem_sign;
        mem_width_e       mem_width;
    } dec_instr_t;

    // Integer pipe dispatch record
    typedef struct packed {
        logic [`XLEN-1:0] pc;
        alu_op_e          op;
        logic [`XLEN-1:0] operand1;
        logic [`XLEN-1:0] operand2;
        reg_idx_t         dst;
        logic             wb_en;
    } ip_instr_t;

    // Load/store pipe dispatch record
    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic             is_store;
        logic [`XLEN-1:0] base;
        logic [11:0]      offset;
        logic [`XLEN-1:0] source;
        logic             mem_sign;
        mem_width_e       mem_width;
        reg_idx_t         dst;
        logic             wb_en;
    } lsp_instr_t;

    // Writeback event, also used for forwarding and busy tracking
    typedef struct packed {
        logic             valid;
        logic             wb_en;
        reg_idx_t         dst;
        logic [`XLEN-1:0] result;
        logic [`XLEN-1:0] pc;
    } wb_t;

endpackage

/* src/core_config.svh */
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// Data path width in bits
`define XLEN 64

// Architectural registers, x0 included
`define REG_COUNT 32

// Data memory depth in XLEN-bit words
`define DMEM_WORDS 64

// Entries in the testbench instruction table
`define TB_TABLE_LEN 160

`endif
